//--- m26_rx_pkg.sv
// Shared definitions for the sensor link receiver
//   Lane word and frame limits
//   Record FIFO depth and address width
//   Record field values and bit positions
//   Register bus addresses and version
//   Channel FSM states and timestamp select codes

package m26_rx_pkg;

    // Lane words and frame limits
    localparam int word_bits = 16;
    localparam int cnt_bits = $clog2(word_bits);
    localparam int max_len = 32;

    // Record FIFO
    localparam int fifo_depth = 16;
    localparam int fifo_aw = $clog2(fifo_depth);

    // Record layout
    localparam int rec_bits = 32;
    localparam int rec_fs_bit = 16;
    localparam int rec_lost_bit = 17;
    localparam int rec_ident_lsb = 20;
    localparam int rec_header_lsb = 24;
    localparam logic [7:0] rec_header = 8'hA5;
    localparam logic [3:0] rec_ident = 4'h3;

    // Register bank
    localparam logic [7:0] version = 8'd1;
    localparam logic [15:0] addr_reset = 16'd0;
    localparam logic [15:0] addr_conf = 16'd2;
    localparam logic [15:0] addr_lost = 16'd3;

    // Per-lane frame tracking
    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_length,
        st_data
    } ch_state_t;

    // Which timestamp half replaces a header word
    typedef enum logic [1:0] {
        ts_none,
        ts_low,
        ts_high
    } ts_sel_t;

endpackage

//--- m26_rx_ch.sv
// Single lane deserializer
//   DELAY-deep input delay line on marker and data
//   MSB-first shift register and bit counter
//   Frame FSM: header, length, data words
//   Oversized lengths abort the frame

`timescale 1ns/10ps

module m26_rx_ch #(
    parameter int DELAY = 1
) (
    input  logic                               CLK_RX,
    input  logic                               rst,
    input  logic                               mkd_rx,
    input  logic                               data_rx,
    output logic                               write,
    output logic                               frame_start,
    output logic [m26_rx_pkg::word_bits-1:0]   data
);

    logic [DELAY-1:0]                     mkd_dly;
    logic [DELAY-1:0]                     dat_dly;
    logic                                 d_mkd;
    logic                                 d_dat;
    logic [m26_rx_pkg::word_bits-2:0]     sreg;
    logic [m26_rx_pkg::word_bits-1:0]     next_word;
    logic [m26_rx_pkg::cnt_bits-1:0]      bit_cnt;
    logic [m26_rx_pkg::word_bits-1:0]     word_cnt;
    logic                                 word_done;
    m26_rx_pkg::ch_state_t                state;

    // Marker delay line
    always_ff @(posedge CLK_RX) begin
        if (rst) begin
            mkd_dly <= '0;
        end else begin
            mkd_dly[0] <= mkd_rx;
            for (int i = 1; i < DELAY; i++) begin
                mkd_dly[i] <= mkd_dly[i-1];
            end
        end
    end

    always_ff @(posedge CLK_RX) begin
        dat_dly[0] <= data_rx;
        for (int i = 1; i < DELAY; i++) begin
            dat_dly[i] <= dat_dly[i-1];
        end
    end

    assign d_mkd = mkd_dly[DELAY-1];
    assign d_dat = dat_dly[DELAY-1];

    // Word is the last 16 delayed bits of a free-running shift
    always_ff @(posedge CLK_RX) begin
        sreg <= {sreg[m26_rx_pkg::word_bits-3:0], d_dat};
    end

    assign next_word = {sreg, d_dat};
    assign word_done = !d_mkd && (state != m26_rx_pkg::st_idle)
                       && (bit_cnt == m26_rx_pkg::cnt_bits'(m26_rx_pkg::word_bits - 1));

    always_ff @(posedge CLK_RX) begin
        if (rst) begin
            state       <= m26_rx_pkg::st_idle;
            bit_cnt     <= '0;
            word_cnt    <= '0;
            write       <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            write       <= 1'b0;
            frame_start <= 1'b0;
            if (d_mkd) begin
                // Marker bit is the header MSB even mid-frame
                state   <= m26_rx_pkg::st_header;
                bit_cnt <= m26_rx_pkg::cnt_bits'(1);
            end else if (state != m26_rx_pkg::st_idle) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (word_done) begin
                    write <= 1'b1;
                    case (state)
                        m26_rx_pkg::st_header: begin
                            frame_start <= 1'b1;
                            state       <= m26_rx_pkg::st_length;
                        end
                        m26_rx_pkg::st_length: begin
                            if (next_word > m26_rx_pkg::word_bits'(m26_rx_pkg::max_len)
                                || next_word == '0) begin
                                state <= m26_rx_pkg::st_idle;
                            end else begin
                                word_cnt <= next_word;
                                state    <= m26_rx_pkg::st_data;
                            end
                        end
                        m26_rx_pkg::st_data: begin
                            word_cnt <= word_cnt - 1'b1;
                            if (word_cnt == m26_rx_pkg::word_bits'(1)) begin
                                state <= m26_rx_pkg::st_idle;
                            end
                        end
                        default: begin
                            state <= m26_rx_pkg::st_idle;
                        end
                    endcase
                end
            end
        end
    end

    // Word held for the write pulse
    always_ff @(posedge CLK_RX) begin
        if (word_done) begin
            data <= next_word;
        end
    end

endmodule

//--- m26_rx_regs.sv
// Byte-wide register bank
//   Soft reset decode merged with the external reset
//   Configuration register: enable and timestamp header
//   Registered read-back of version, configuration and lost count

`timescale 1ns/10ps

module m26_rx_regs (
    input  logic        CLK_RX,
    input  logic        RST_SYNC,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_wr,
    input  logic        bus_rd,
    output logic [7:0]  bus_data_out,
    input  logic [7:0]  lost_cnt,
    output logic        core_rst,
    output logic        conf_en,
    output logic        conf_ts
);

    logic soft_rst;

    assign soft_rst = bus_wr && (bus_add == m26_rx_pkg::addr_reset);

    // Core reset one cycle after either source
    always_ff @(posedge CLK_RX) begin
        core_rst <= RST_SYNC | soft_rst;
    end

    // A soft reset also disables the receiver
    always_ff @(posedge CLK_RX) begin
        if (core_rst) begin
            conf_en <= 1'b0;
            conf_ts <= 1'b0;
        end else if (bus_wr && bus_add == m26_rx_pkg::addr_conf) begin
            conf_en <= bus_data_in[0];
            conf_ts <= bus_data_in[1];
        end
    end

    always_ff @(posedge CLK_RX) begin
        if (bus_rd) begin
            case (bus_add)
                m26_rx_pkg::addr_reset: bus_data_out <= m26_rx_pkg::version;
                m26_rx_pkg::addr_conf:  bus_data_out <= {6'b0, conf_ts, conf_en};
                m26_rx_pkg::addr_lost:  bus_data_out <= lost_cnt;
                default:                bus_data_out <= 8'h00;
            endcase
        end
    end

endmodule

//--- m26_rx_merge.sv
// Lane merge and record assembly
//   Lane select between the two staggered write pulses
//   Timestamp substitution of the header words
//   Lost-data flag and saturating lost counter
//   Record packing with header and ident fields

`timescale 1ns/10ps

module m26_rx_merge (
    input  logic                               CLK_RX,
    input  logic                               rst,
    input  logic                               write0,
    input  logic                               frame_start0,
    input  logic [m26_rx_pkg::word_bits-1:0]   data0,
    input  logic                               write1,
    input  logic                               frame_start1,
    input  logic [m26_rx_pkg::word_bits-1:0]   data1,
    input  logic                               conf_en,
    input  logic                               conf_ts,
    input  logic [31:0]                        timestamp,
    input  logic                               fifo_full,
    output logic                               fifo_wr,
    output logic [m26_rx_pkg::rec_bits-1:0]    fifo_data,
    output logic [7:0]                         lost_cnt
);

    m26_rx_pkg::ts_sel_t                  ts_sel;
    logic [31:0]                          ts_save;
    logic [m26_rx_pkg::word_bits-1:0]     lane_data;
    logic [m26_rx_pkg::word_bits-1:0]     data_field;
    logic                                 lane_fs;
    logic                                 lost_flag;

    // Lanes never write in the same cycle
    assign lane_data = write0 ? data0 : data1;
    assign lane_fs   = write0 ? frame_start0 : frame_start1;
    assign fifo_wr   = conf_en && (write0 || write1);

    always_comb begin
        if (conf_ts && write0 && frame_start0) begin
            ts_sel = m26_rx_pkg::ts_low;
        end else if (conf_ts && write1 && frame_start1) begin
            ts_sel = m26_rx_pkg::ts_high;
        end else begin
            ts_sel = m26_rx_pkg::ts_none;
        end
    end

    // Whole timestamp kept at the lane 0 header for the lane 1 header
    always_ff @(posedge CLK_RX) begin
        if (write0 && frame_start0) begin
            ts_save <= timestamp;
        end
    end

    always_comb begin
        case (ts_sel)
            m26_rx_pkg::ts_low:  data_field = timestamp[15:0];
            m26_rx_pkg::ts_high: data_field = ts_save[31:16];
            default:             data_field = lane_data;
        endcase
    end

    always_ff @(posedge CLK_RX) begin
        if (rst) begin
            lost_cnt <= 8'd0;
        end else if (fifo_wr && fifo_full && lost_cnt != 8'hFF) begin
            lost_cnt <= lost_cnt + 8'd1;
        end
    end

    // Flag follows the FIFO state of the latest write
    always_ff @(posedge CLK_RX) begin
        if (rst) begin
            lost_flag <= 1'b0;
        end else if (fifo_wr) begin
            lost_flag <= fifo_full;
        end
    end

    always_comb begin
        fifo_data = '0;
        fifo_data[m26_rx_pkg::word_bits-1:0]    = data_field;
        fifo_data[m26_rx_pkg::rec_fs_bit]       = lane_fs;
        fifo_data[m26_rx_pkg::rec_lost_bit]     = lost_flag;
        fifo_data[m26_rx_pkg::rec_ident_lsb +: 4]  = m26_rx_pkg::rec_ident;
        fifo_data[m26_rx_pkg::rec_header_lsb +: 8] = m26_rx_pkg::rec_header;
    end

endmodule

//--- m26_rx_fifo.sv
// Synchronous record FIFO
//   Circular buffer with read and write pointers
//   Occupancy count for full and empty
//   First-word fall-through read data

`timescale 1ns/10ps

module m26_rx_fifo (
    input  logic                             CLK_RX,
    input  logic                             rst,
    input  logic                             wr,
    input  logic [m26_rx_pkg::rec_bits-1:0]  din,
    input  logic                             rd,
    output logic [m26_rx_pkg::rec_bits-1:0]  dout,
    output logic                             full,
    output logic                             empty
);

    logic [m26_rx_pkg::rec_bits-1:0]  mem [m26_rx_pkg::fifo_depth];
    logic [m26_rx_pkg::fifo_aw-1:0]   wr_ptr;
    logic [m26_rx_pkg::fifo_aw-1:0]   rd_ptr;
    logic [m26_rx_pkg::fifo_aw:0]     count;
    logic                             do_wr;
    logic                             do_rd;

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;
    assign full  = (count == (m26_rx_pkg::fifo_aw + 1)'(m26_rx_pkg::fifo_depth));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    always_ff @(posedge CLK_RX) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge CLK_RX) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- m26_rx_core.sv
// Receiver top level
//   Two lane channels with staggered input delays
//   Register bank with soft reset
//   Lane merge and record FIFO
//   Lost-data status output

`timescale 1ns/10ps

module m26_rx_core (
    input  logic         CLK_RX,
    input  logic         RST_SYNC,
    input  logic         mkd_rx,
    input  logic [1:0]   data_rx,
    input  logic [31:0]  timestamp,
    input  logic         fifo_read,
    output logic         fifo_empty,
    output logic [31:0]  fifo_data,
    input  logic [15:0]  bus_add,
    input  logic [7:0]   bus_data_in,
    input  logic         bus_wr,
    input  logic         bus_rd,
    output logic [7:0]   bus_data_out,
    output logic         lost_error
);

    logic                                core_rst;
    logic                                conf_en;
    logic                                conf_ts;
    logic [7:0]                          lost_cnt;
    logic                                ch0_write;
    logic                                ch0_fs;
    logic [m26_rx_pkg::word_bits-1:0]    ch0_data;
    logic                                ch1_write;
    logic                                ch1_fs;
    logic [m26_rx_pkg::word_bits-1:0]    ch1_data;
    logic                                rec_wr;
    logic [m26_rx_pkg::rec_bits-1:0]     rec_data;
    logic                                fifo_full;

    m26_rx_regs regs_inst (
        .CLK_RX       (CLK_RX),
        .RST_SYNC     (RST_SYNC),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .lost_cnt     (lost_cnt),
        .core_rst     (core_rst),
        .conf_en      (conf_en),
        .conf_ts      (conf_ts)
    );

    // Four cycles of stagger keep the lane writes apart
    m26_rx_ch #(.DELAY(1)) ch0 (
        .CLK_RX      (CLK_RX),
        .rst         (core_rst),
        .mkd_rx      (mkd_rx),
        .data_rx     (data_rx[0]),
        .write       (ch0_write),
        .frame_start (ch0_fs),
        .data        (ch0_data)
    );

    m26_rx_ch #(.DELAY(5)) ch1 (
        .CLK_RX      (CLK_RX),
        .rst         (core_rst),
        .mkd_rx      (mkd_rx),
        .data_rx     (data_rx[1]),
        .write       (ch1_write),
        .frame_start (ch1_fs),
        .data        (ch1_data)
    );

    m26_rx_merge merge_inst (
        .CLK_RX       (CLK_RX),
        .rst          (core_rst),
        .write0       (ch0_write),
        .frame_start0 (ch0_fs),
        .data0        (ch0_data),
        .write1       (ch1_write),
        .frame_start1 (ch1_fs),
        .data1        (ch1_data),
        .conf_en      (conf_en),
        .conf_ts      (conf_ts),
        .timestamp    (timestamp),
        .fifo_full    (fifo_full),
        .fifo_wr      (rec_wr),
        .fifo_data    (rec_data),
        .lost_cnt     (lost_cnt)
    );

    m26_rx_fifo fifo_inst (
        .CLK_RX (CLK_RX),
        .rst    (core_rst),
        .wr     (rec_wr),
        .din    (rec_data),
        .rd     (fifo_read),
        .dout   (fifo_data),
        .full   (fifo_full),
        .empty  (fifo_empty)
    );

    assign lost_error = (lost_cnt != 8'd0);

endmodule

//--- m26_rx_assertions.sv
// Concurrent checks on the receiver top level
//   FIFO never empty and full together
//   Lane write pulses never coincide
//   Lost status low once the core reset has acted

`timescale 1ns/10ps

module m26_rx_assertions (
    input logic CLK_RX,
    input logic core_rst,
    input logic fifo_empty,
    input logic fifo_full,
    input logic ch0_write,
    input logic ch1_write,
    input logic lost_error
);

    fifo_flags_exclusive: assert property (@(posedge CLK_RX) !(fifo_empty && fifo_full))
        else $error("FIFO reports empty and full at once");

    // Stagger of four cycles between the lanes
    lane_writes_apart: assert property (@(posedge CLK_RX) disable iff (core_rst)
        !(ch0_write && ch1_write))
        else $error("Both lane write pulses high in one cycle");

    lost_cleared_by_reset: assert property (@(posedge CLK_RX) core_rst |=> !lost_error)
        else $error("lost_error high after core reset");

endmodule

bind m26_rx_core m26_rx_assertions m26_rx_assertions_inst (
    .CLK_RX     (CLK_RX),
    .core_rst   (core_rst),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .ch0_write  (ch0_write),
    .ch1_write  (ch1_write),
    .lost_error (lost_error)
);

//--- tb_m26_rx.sv
// Testbench for the sensor link receiver
//   Register read-back checks
//   Table of frame tests with serial lane generator and FIFO reader
//   Record model with timestamp headers, drops and the lost flag
//   Soft reset test, compare tasks and watchdog

`timescale 1ns/10ps

module tb_m26_rx;

    localparam int clk_period = 40;
    localparam int settle_cycles = 16;
    localparam int rec_timeout = 64;
    localparam int max_words = m26_rx_pkg::max_len + 2;
    localparam int n_tests = 12;

    // One row per frame test
    localparam int t_len0 [n_tests] = '{4, 3, 2, 40, 6, 10, 3, 32, 32, 32, 32, 32};
    localparam int t_len1 [n_tests] = '{4, 6, 2, 5, 40, 10, 3, 32, 32, 32, 32, 32};
    localparam bit t_en [n_tests] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1,
                                      1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    localparam bit t_ts [n_tests] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                                      1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    localparam logic [31:0] t_tsval [n_tests] = '{32'h0, 32'h9A3C_51E7, 32'h0, 32'h0,
                                                  32'h0, 32'h0, 32'h0F1E_2D3C, 32'h0,
                                                  32'h0, 32'h0, 32'h0, 32'h0};
    localparam bit t_stall [n_tests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
                                         1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    localparam logic [7:0] t_lost [n_tests] = '{8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd8,
                                               8'd8, 8'd60, 8'd112, 8'd164, 8'd216, 8'd255};

    logic         CLK_RX;
    logic         RST_SYNC;
    logic         mkd_rx;
    logic [1:0]   data_rx;
    logic [31:0]  timestamp;
    logic         fifo_read;
    logic         fifo_empty;
    logic [31:0]  fifo_data;
    logic [15:0]  bus_add;
    logic [7:0]   bus_data_in;
    logic         bus_wr;
    logic         bus_rd;
    logic [7:0]   bus_data_out;
    logic         lost_error;

    int seed;
    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int n0;
    int n1;
    bit lost_model;
    logic [15:0] lane0 [max_words];
    logic [15:0] lane1 [max_words];
    logic [31:0] exp_q [$];
    logic [15:0] hdr_seen [$];

    m26_rx_core m26_rx_core_inst (
        .CLK_RX       (CLK_RX),
        .RST_SYNC     (RST_SYNC),
        .mkd_rx       (mkd_rx),
        .data_rx      (data_rx),
        .timestamp    (timestamp),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .lost_error   (lost_error)
    );

    initial begin
        CLK_RX = 1'b0;
        forever #(clk_period / 2) CLK_RX = ~CLK_RX;
    end

    task automatic check_record(input string name, input logic [31:0] want,
                                input logic [31:0] got);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, want, got);
            err_cnt++;
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] want,
                              input logic [15:0] got);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, want, got);
            err_cnt++;
        end
    endtask

    task automatic check_reg(input string name, input logic [7:0] want, input logic [7:0] got);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, want, got);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, want, got);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] value);
        @(posedge CLK_RX);
        #2;
        bus_add = addr;
        bus_data_in = value;
        bus_wr = 1'b1;
        @(posedge CLK_RX);
        #2;
        bus_wr = 1'b0;
    endtask

    // Read data is registered and valid one cycle after the pulse
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] value);
        @(posedge CLK_RX);
        #2;
        bus_add = addr;
        bus_rd = 1'b1;
        @(posedge CLK_RX);
        #2;
        bus_rd = 1'b0;
        value = bus_data_out;
    endtask

    // Words per lane where an oversized or zero length ends after the length word
    function automatic int lane_words(input int len);
        if (len > m26_rx_pkg::max_len || len == 0) begin
            return 2;
        end
        return len + 2;
    endfunction

    task automatic build_lanes(input int len0, input int len1);
        n0 = lane_words(len0);
        n1 = lane_words(len1);
        for (int k = 0; k < max_words; k++) begin
            lane0[k] = 16'($random(seed));
            lane1[k] = 16'($random(seed));
        end
        lane0[1] = 16'(len0);
        lane1[1] = 16'(len1);
    endtask

    // Lane 0 word k is written before lane 1 word k
    task automatic build_expected(input int t);
        logic [15:0] d;
        int n_wr;
        n_wr = 0;
        exp_q.delete();
        for (int k = 0; k < max_words; k++) begin
            for (int lane = 0; lane < 2; lane++) begin
                if (t_en[t] && k < ((lane == 0) ? n0 : n1)) begin
                    d = (lane == 0) ? lane0[k] : lane1[k];
                    if (k == 0 && t_ts[t]) begin
                        d = (lane == 0) ? t_tsval[t][15:0] : t_tsval[t][31:16];
                    end
                    if (!t_stall[t] || n_wr < m26_rx_pkg::fifo_depth) begin
                        exp_q.push_back({m26_rx_pkg::rec_header, m26_rx_pkg::rec_ident,
                                         2'b00, lost_model, k == 0, d});
                    end
                    lost_model = t_stall[t] && (n_wr >= m26_rx_pkg::fifo_depth);
                    n_wr++;
                end
            end
        end
    endtask

    // Both lanes MSB first with the marker on the first header bit
    task automatic send_lanes();
        int nbits;
        int w;
        int b;
        nbits = 16 * ((n0 > n1) ? n0 : n1);
        for (int i = 0; i < nbits; i++) begin
            w = i / 16;
            b = 15 - (i % 16);
            @(posedge CLK_RX);
            #2;
            mkd_rx = (i == 0);
            data_rx[0] = (w < n0) ? lane0[w][b] : 1'b0;
            data_rx[1] = (w < n1) ? lane1[w][b] : 1'b0;
        end
        @(posedge CLK_RX);
        #2;
        mkd_rx = 1'b0;
        data_rx = 2'b00;
    endtask

    task automatic drain_fifo();
        int waited;
        logic [31:0] want;
        while (exp_q.size() > 0) begin
            waited = 0;
            while (fifo_empty && waited < rec_timeout) begin
                @(posedge CLK_RX);
                #2;
                waited++;
            end
            if (fifo_empty) begin
                $display("ERROR at %0t: %0d expected records never left the FIFO",
                         $time, exp_q.size());
                err_cnt++;
                exp_q.delete();
            end else begin
                want = exp_q.pop_front();
                check_record("fifo_data", want, fifo_data);
                if (fifo_data[16]) begin
                    hdr_seen.push_back(fifo_data[15:0]);
                end
                fifo_read = 1'b1;
                @(posedge CLK_RX);
                #2;
                fifo_read = 1'b0;
            end
        end
    endtask

    initial begin
        longint limit;
        limit = 16 * 4;
        for (int i = 0; i < n_tests; i++) begin
            limit += 16 * ((lane_words(t_len0[i]) > lane_words(t_len1[i])) ?
                           lane_words(t_len0[i]) : lane_words(t_len1[i]));
        end
        #(limit * clk_period * 4);
        $display("ERROR: timeout, the tests did not finish by %0t", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int errs;
        logic [7:0] rd_val;
        RST_SYNC = 1'b1;
        mkd_rx = 1'b0;
        data_rx = 2'b00;
        timestamp = 32'h0;
        fifo_read = 1'b0;
        bus_add = 16'h0;
        bus_data_in = 8'h0;
        bus_wr = 1'b0;
        bus_rd = 1'b0;
        seed = 60694;
        err_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        lost_model = 1'b0;
        repeat (3) @(posedge CLK_RX);
        #2;
        RST_SYNC = 1'b0;
        // Core reset trails the pin by one cycle
        repeat (2) @(posedge CLK_RX);
        #2;

        errs = err_cnt;
        bus_read(m26_rx_pkg::addr_reset, rd_val);
        check_reg("version", 8'd1, rd_val);
        bus_write(m26_rx_pkg::addr_conf, 8'h03);
        bus_read(m26_rx_pkg::addr_conf, rd_val);
        check_reg("conf", 8'h03, rd_val);
        bus_write(m26_rx_pkg::addr_conf, 8'h02);
        bus_read(m26_rx_pkg::addr_conf, rd_val);
        check_reg("conf", 8'h02, rd_val);
        // Low byte matches the configuration address
        bus_read(16'h0102, rd_val);
        check_reg("unused address", 8'h00, rd_val);
        bus_read(m26_rx_pkg::addr_lost, rd_val);
        check_reg("lost count", 8'h00, rd_val);
        check_bit("lost_error", 1'b0, lost_error);
        check_bit("fifo_empty", 1'b1, fifo_empty);
        report_test("register read-back", errs);

        for (int t = 0; t < n_tests; t++) begin
            errs = err_cnt;
            bus_write(m26_rx_pkg::addr_conf, {6'b0, t_ts[t], t_en[t]});
            timestamp = t_tsval[t];
            build_lanes(t_len0[t], t_len1[t]);
            build_expected(t);
            hdr_seen.delete();
            fork
                send_lanes();
                if (!t_stall[t]) drain_fifo();
            join
            if (t_stall[t]) begin
                // Longer than the lane delay plus merge latency
                repeat (settle_cycles) @(posedge CLK_RX);
                #2;
                drain_fifo();
            end
            repeat (settle_cycles) @(posedge CLK_RX);
            #2;
            check_bit("fifo_empty", 1'b1, fifo_empty);
            if (t_ts[t] && t_en[t]) begin
                if (hdr_seen.size() == 2) begin
                    check_word("ch0 header", t_tsval[t][15:0], hdr_seen[0]);
                    check_word("ch1 header", t_tsval[t][31:16], hdr_seen[1]);
                end else begin
                    $display("ERROR at %0t: expected two header records, saw %0d",
                             $time, hdr_seen.size());
                    err_cnt++;
                end
            end
            bus_read(m26_rx_pkg::addr_lost, rd_val);
            check_reg("lost count", t_lost[t], rd_val);
            check_bit("lost_error", t_lost[t] != 8'd0, lost_error);
            report_test($sformatf("frame test %0d", t), errs);
        end

        // Leave records in the FIFO and then soft reset
        errs = err_cnt;
        bus_write(m26_rx_pkg::addr_conf, 8'h01);
        build_lanes(2, 2);
        send_lanes();
        repeat (settle_cycles) @(posedge CLK_RX);
        #2;
        check_bit("fifo_empty", 1'b0, fifo_empty);
        check_bit("lost_error", 1'b1, lost_error);
        bus_write(m26_rx_pkg::addr_reset, 8'h00);
        bus_read(m26_rx_pkg::addr_lost, rd_val);
        check_reg("lost count", 8'h00, rd_val);
        check_bit("lost_error", 1'b0, lost_error);
        bus_read(m26_rx_pkg::addr_conf, rd_val);
        check_reg("conf", 8'h00, rd_val);
        check_bit("fifo_empty", 1'b1, fifo_empty);
        report_test("soft reset", errs);

        $display("Tests: %0d passed, %0d failed, %0d check errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
m26_rx_pkg.sv
m26_rx_ch.sv
m26_rx_regs.sv
m26_rx_merge.sv
m26_rx_fifo.sv
m26_rx_core.sv
m26_rx_assertions.sv
tb_m26_rx.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_m26_rx
FILE_LIST  := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_TEXT  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_TEXT)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
